/* Bender.yml */
package:
  name: iagc

export_include_dirs:
  - verilog

sources:
  - target: rtl
    include_dirs:
      - verilog
    files:
      - verilog/iagc_data_pkg.sv
      - verilog/iagc_reg_pkg.sv
      - verilog/iagc_regs.sv
      - verilog/iagc_sequencer.sv
      - verilog/phase_detector.sv
      - verilog/polarity_corrector.sv
      - verilog/iagc_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/iagc_sva.sv
      - bench/iagc_tb.sv

/* bench/iagc_sva.sv */
`timescale 1ns/1ps
`include "iagc_defines.svh"

module iagc_sva (
    input logic                           i_clock,
    input logic                           i_arst_n,
    input logic                           i_sample,
    input iagc_data_pkg::iagc_status_e    i_iagc_status,
    input iagc_reg_pkg::iagc_cfg_t        i_cfg,
    input iagc_data_pkg::sample_pair_t    i_samples,
    input logic                           i_in_phase,
    input logic signed [`IAGC_DATA_W-1:0] i_error_word,
    input logic                           i_valid_word,
    input logic                           i_pready
);

    localparam logic signed [`IAGC_DATA_W-1:0] MOST_NEG = {1'b1, {(`IAGC_DATA_W-1){1'b0}}};
    localparam logic signed [`IAGC_DATA_W-1:0] MOST_POS = {1'b0, {(`IAGC_DATA_W-1){1'b1}}};

    int                             violations = 0;
    logic [`IAGC_DECIM_W:0]         gap;
    logic signed [`IAGC_DATA_W-1:0] expected_q;

    // Cycles since RUN was entered or since the last strobe
    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            gap <= '0;
        end else if (i_iagc_status != iagc_data_pkg::RUN) begin
            gap <= '0;
        end else if (i_sample) begin
            gap <= 1;
        end else begin
            gap <= gap + 1'b1;
        end
    end

    // Word the corrector should present one cycle after a strobe
    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            expected_q <= '0;
        end else if (i_sample && i_in_phase) begin
            expected_q <= i_samples.error;
        end else if (i_sample) begin
            expected_q <= (i_samples.error == MOST_NEG) ? MOST_POS : -i_samples.error;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Properties
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    strobe_spacing: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        (i_sample && i_iagc_status == iagc_data_pkg::RUN) |-> gap == i_cfg.decim + 1'b1)
        else begin
            violations++;
            $error("strobe spacing is not decim+1 cycles");
        end

    valid_after_strobe: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        i_sample |=> i_valid_word)
        else begin
            violations++;
            $error("o_valid missing one cycle after a strobe");
        end

    valid_only_after_strobe: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        !i_sample |=> !i_valid_word)
        else begin
            violations++;
            $error("o_valid raised without a strobe");
        end

    corrected_word: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        i_valid_word |-> i_error_word == expected_q)
        else begin
            violations++;
            $error("o_error does not match the phase corrected sample");
        end

    ready_high: assert property (@(posedge i_clock) i_pready)
        else begin
            violations++;
            $error("o_pready dropped low");
        end

    in_phase_clear_in_reset: assert property (@(posedge i_clock) !i_arst_n |-> !i_in_phase)
        else begin
            violations++;
            $error("o_in_phase set during reset");
        end

endmodule

bind iagc_top iagc_sva u_sva (
    .i_clock       (i_clock),
    .i_arst_n      (i_arst_n),
    .i_sample      (sample),
    .i_iagc_status (iagc_status),
    .i_cfg         (cfg),
    .i_samples     (i_samples),
    .i_in_phase    (o_in_phase),
    .i_error_word  (o_error),
    .i_valid_word  (o_valid),
    .i_pready      (o_pready)
);

/* bench/iagc_tb.sv */
`timescale 1ns/1ps
`include "iagc_defines.svh"

module iagc_tb;

    localparam int TIMEOUT = 400;

    // Sample driver modes
    localparam int MODE_IDLE   = 0;
    localparam int MODE_AGREE  = 1;
    localparam int MODE_OPPOSE = 2;
    localparam int MODE_MIX    = 3;
    localparam int MODE_MINNEG = 4;

    logic                           i_clock;
    logic                           i_arst_n;
    logic                           i_psel;
    logic                           i_penable;
    logic                           i_pwrite;
    logic [`IAGC_ADDR_W-1:0]        i_paddr;
    logic [31:0]                    i_pwdata;
    logic [31:0]                    o_prdata;
    logic                           o_pready;
    logic                           o_pslverr;
    iagc_data_pkg::sample_pair_t    i_samples;
    logic signed [`IAGC_DATA_W-1:0] o_error;
    logic                           o_valid;
    logic                           o_in_phase;

    int                             mode;
    logic                           toggle;
    logic [31:0]                    rnd;
    logic signed [`IAGC_DATA_W-1:0] prev_err;
    logic signed [`IAGC_DATA_W-1:0] cur_err;
    logic [31:0]                    rdata;
    logic                           slverr;
    logic [7:0]                     count0;
    int                             valid_seen;
    int                             test_errors;
    int                             total_errors;
    int                             tests_done;
    string                          current_test;

    iagc_top dut (
        .i_clock   (i_clock),
        .i_arst_n  (i_arst_n),
        .i_psel    (i_psel),
        .i_penable (i_penable),
        .i_pwrite  (i_pwrite),
        .i_paddr   (i_paddr),
        .i_pwdata  (i_pwdata),
        .o_prdata  (o_prdata),
        .o_pready  (o_pready),
        .o_pslverr (o_pslverr),
        .i_samples (i_samples),
        .o_error   (o_error),
        .o_valid   (o_valid),
        .o_in_phase(o_in_phase)
    );

    initial i_clock = 1'b0;
    always #5 i_clock = ~i_clock;

    function automatic logic signed [`IAGC_DATA_W-1:0] sat_negate(
        input logic signed [`IAGC_DATA_W-1:0] x
    );
        if (x == {1'b1, {(`IAGC_DATA_W-1){1'b0}}}) begin
            return {1'b0, {(`IAGC_DATA_W-1){1'b1}}};
        end
        return -x;
    endfunction

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected == actual) else begin
            test_errors++;
            $display("ERROR %s/%s expected %h actual %h", current_test, name, expected, actual);
        end
    endtask

    task automatic give_up(input string what);
        $display("timeout while waiting for %s", what);
        $display("=== FAIL ===");
        $finish;
    endtask

    task automatic begin_test(input string name);
        current_test = name;
        test_errors  = 0;
    endtask

    task automatic finish_test();
        $display("test %s finished with %0d errors", current_test, test_errors);
        total_errors += test_errors;
        tests_done++;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // APB master
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic apb_access(input logic write, input logic [`IAGC_ADDR_W-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rd,
                              output logic err);
        int waited;
        waited = 0;
        @(posedge i_clock);
        #1;
        i_psel    = 1'b1;
        i_penable = 1'b0;
        i_pwrite  = write;
        i_paddr   = addr;
        i_pwdata  = wdata;
        @(posedge i_clock);
        #1;
        i_penable = 1'b1;
        @(negedge i_clock);
        while (!o_pready) begin
            waited++;
            if (waited > TIMEOUT) give_up("APB ready");
            @(negedge i_clock);
        end
        rd  = o_prdata;
        err = o_pslverr;
        @(posedge i_clock);
        #1;
        i_psel    = 1'b0;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
    endtask

    task automatic wait_windows(input int count);
        logic [31:0] rd;
        logic        err;
        logic [7:0]  start;
        int          polls;
        polls = 0;
        apb_access(1'b0, iagc_reg_pkg::REG_STATUS, 32'h0, rd, err);
        start = rd[7:0];
        while (int'(8'(rd[7:0] - start)) < count) begin
            polls++;
            if (polls > TIMEOUT) give_up("the window count to advance");
            apb_access(1'b0, iagc_reg_pkg::REG_STATUS, 32'h0, rd, err);
        end
    endtask

    // Every valid word is the saturated negation of the error driven at its strobe
    task automatic check_corrected_words(input int words);
        int seen;
        int cycles;
        seen   = 0;
        cycles = 0;
        while (seen < words) begin
            @(negedge i_clock);
            cycles++;
            if (cycles > TIMEOUT) give_up("a valid corrector word");
            if (o_valid) begin
                check_equal("corrector", sat_negate(prev_err), o_error);
                seen++;
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sample driver
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        void'($urandom(32'hfcf4b941));
        i_samples = '0;
        toggle    = 1'b0;
        prev_err  = '0;
        cur_err   = '0;
        forever begin
            @(posedge i_clock);
            #1;
            rnd      = $urandom;
            toggle   = ~toggle;
            prev_err = cur_err;
            i_samples.reference = rnd[`IAGC_DATA_W-1:0];
            i_samples.error     = rnd[2*`IAGC_DATA_W-1:`IAGC_DATA_W];
            case (mode)
                MODE_AGREE:  i_samples.error[`IAGC_DATA_W-1] = rnd[`IAGC_DATA_W-1];
                MODE_OPPOSE: i_samples.error[`IAGC_DATA_W-1] = ~rnd[`IAGC_DATA_W-1];
                MODE_MIX:    i_samples.error[`IAGC_DATA_W-1] = rnd[`IAGC_DATA_W-1] ^ toggle;
                MODE_MINNEG: begin
                    i_samples.reference = 14'h0123;
                    i_samples.error     = 14'h2000;
                end
                default:     i_samples = '0;
            endcase
            cur_err = i_samples.error;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        i_arst_n     = 1'b0;
        i_psel       = 1'b0;
        i_penable    = 1'b0;
        i_pwrite     = 1'b0;
        i_paddr      = '0;
        i_pwdata     = '0;
        mode         = MODE_IDLE;
        test_errors  = 0;
        total_errors = 0;
        tests_done   = 0;
        current_test = "";
        repeat (10) @(posedge i_clock);
        #1;
        i_arst_n = 1'b1;

        begin_test("register_access");
        apb_access(1'b0, iagc_reg_pkg::REG_CTRL, 32'h0, rdata, slverr);
        check_equal("reset_ctrl", 32'h0, rdata);
        apb_access(1'b0, iagc_reg_pkg::REG_WINDOW, 32'h0, rdata, slverr);
        check_equal("reset_window", 32'h1, rdata);
        apb_access(1'b0, iagc_reg_pkg::REG_DECIM, 32'h0, rdata, slverr);
        check_equal("reset_decim", 32'h0, rdata);
        apb_access(1'b0, iagc_reg_pkg::REG_STATUS, 32'h0, rdata, slverr);
        check_equal("reset_status", 32'h0, rdata);
        apb_access(1'b1, iagc_reg_pkg::REG_WINDOW, 32'h0000_1234, rdata, slverr);
        check_equal("write_slverr", 32'h0, 32'(slverr));
        // Upper bits of DECIM are reserved and must read back as zero
        apb_access(1'b1, iagc_reg_pkg::REG_DECIM, 32'h0000_015a, rdata, slverr);
        apb_access(1'b1, iagc_reg_pkg::REG_CTRL, 32'h0000_0001, rdata, slverr);
        apb_access(1'b0, iagc_reg_pkg::REG_CTRL, 32'h0, rdata, slverr);
        check_equal("readback_ctrl", 32'h1, rdata);
        apb_access(1'b0, iagc_reg_pkg::REG_WINDOW, 32'h0, rdata, slverr);
        check_equal("readback_window", 32'h0000_1234, rdata);
        apb_access(1'b0, iagc_reg_pkg::REG_DECIM, 32'h0, rdata, slverr);
        check_equal("readback_decim", 32'h0000_005a, rdata);
        apb_access(1'b0, 4'h2, 32'h0, rdata, slverr);
        check_equal("unmapped_slverr", 32'h1, 32'(slverr));
        apb_access(1'b1, iagc_reg_pkg::REG_STATUS, 32'h0000_00ff, rdata, slverr);
        check_equal("status_write_slverr", 32'h1, 32'(slverr));
        apb_access(1'b1, iagc_reg_pkg::REG_CTRL, 32'h0, rdata, slverr);
        finish_test();

        begin_test("in_phase_decision");
        apb_access(1'b1, iagc_reg_pkg::REG_WINDOW, 32'd8, rdata, slverr);
        apb_access(1'b1, iagc_reg_pkg::REG_DECIM, 32'd2, rdata, slverr);
        mode = MODE_AGREE;
        apb_access(1'b1, iagc_reg_pkg::REG_CTRL, 32'h1, rdata, slverr);
        wait_windows(2);
        check_equal("in_phase", 32'h1, 32'(o_in_phase));
        finish_test();

        begin_test("out_of_phase_and_tie");
        mode = MODE_OPPOSE;
        wait_windows(2);
        check_equal("out_of_phase", 32'h0, 32'(o_in_phase));
        apb_access(1'b1, iagc_reg_pkg::REG_WINDOW, 32'd4, rdata, slverr);
        // Strobes every 3 cycles hit the toggle on alternate values, two of each per window
        mode = MODE_MIX;
        wait_windows(2);
        check_equal("tie_rule", 32'h1, 32'(o_in_phase));
        finish_test();

        begin_test("corrector");
        mode = MODE_OPPOSE;
        wait_windows(2);
        check_equal("corrector_phase", 32'h0, 32'(o_in_phase));
        check_corrected_words(6);
        mode = MODE_MINNEG;
        check_corrected_words(4);
        check_equal("corrector_saturation", 32'h0000_1fff, 32'(o_error));
        finish_test();

        begin_test("disable");
        // Bring the decision to 1 so that holding it differs from clearing it
        mode = MODE_AGREE;
        wait_windows(2);
        check_equal("in_phase_before_disable", 32'h1, 32'(o_in_phase));
        apb_access(1'b1, iagc_reg_pkg::REG_CTRL, 32'h0, rdata, slverr);
        repeat (2) @(posedge i_clock);
        apb_access(1'b0, iagc_reg_pkg::REG_STATUS, 32'h0, rdata, slverr);
        count0     = rdata[7:0];
        valid_seen = 0;
        repeat (40) begin
            @(negedge i_clock);
            if (o_valid) valid_seen++;
        end
        check_equal("disable_valid", 32'h0, 32'(valid_seen));
        apb_access(1'b0, iagc_reg_pkg::REG_STATUS, 32'h0, rdata, slverr);
        check_equal("disable_win_count", 32'(count0), 32'(rdata[7:0]));
        check_equal("disable_in_phase", 32'h1, 32'(o_in_phase));
        finish_test();

        $display("%0d tests run, %0d check errors, %0d assertion failures",
                 tests_done, total_errors, dut.u_sva.violations);
        if (total_errors == 0 && dut.u_sva.violations == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+verilog
verilog/iagc_data_pkg.sv
verilog/iagc_reg_pkg.sv
verilog/iagc_regs.sv
verilog/iagc_sequencer.sv
verilog/phase_detector.sv
verilog/polarity_corrector.sv
verilog/iagc_top.sv
bench/iagc_sva.sv
bench/iagc_tb.sv

/* verilog/iagc_data_pkg.sv */
`include "iagc_defines.svh"

package iagc_data_pkg;

    // One strobed pair from the dual channel ADC
    typedef struct packed {
        logic signed [`IAGC_DATA_W-1:0] reference;
        logic signed [`IAGC_DATA_W-1:0] error;
    } sample_pair_t;

    // Status word of the IAGC loop
    typedef enum logic [3:0] {
        RESET = 4'd0,
        INIT  = 4'd1,
        RUN   = 4'd2
    } iagc_status_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Phase detector FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [1:0] {
        D_INIT,
        D_SAMPLE,
        D_DETECT
    } detect_state_e;

endpackage

/* verilog/iagc_defines.svh */
`ifndef IAGC_DEFINES_SVH
`define IAGC_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Datapath widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Width of one ADC sample, two's complement
`define IAGC_DATA_W 14

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Configuration widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Number of strobed pairs in one detection window
`define IAGC_WINDOW_W 16

// Decimation count, the strobe period is decim+1 clocks
`define IAGC_DECIM_W 8

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// APB byte offset width, four word registers
`define IAGC_ADDR_W 4

`endif

/* verilog/iagc_reg_pkg.sv */
`include "iagc_defines.svh"

package iagc_reg_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Register map
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam logic [`IAGC_ADDR_W-1:0] REG_CTRL   = 4'h0;
    localparam logic [`IAGC_ADDR_W-1:0] REG_WINDOW = 4'h4;
    localparam logic [`IAGC_ADDR_W-1:0] REG_DECIM  = 4'h8;
    localparam logic [`IAGC_ADDR_W-1:0] REG_STATUS = 4'hC;

    // Bit of CTRL that enables the loop
    localparam int CTRL_ENABLE_BIT = 0;

    // Completed window counter, wraps
    localparam int WIN_COUNT_W = 8;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Register block traffic
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Software configuration seen by the sequencer and the detector
    typedef struct packed {
        logic                     enable;
        logic [`IAGC_WINDOW_W-1:0] window;
        logic [`IAGC_DECIM_W-1:0]  decim;
    } iagc_cfg_t;

    // Read back through STATUS, in_phase lands on bit 8
    typedef struct packed {
        logic                   in_phase;
        logic [WIN_COUNT_W-1:0] win_count;
    } iagc_stat_t;

endpackage

/* verilog/iagc_regs.sv */
`timescale 1ns/1ps
`include "iagc_defines.svh"

module iagc_regs (
    input  logic                     i_clock,
    input  logic                     i_arst_n,
    input  logic                     i_psel,
    input  logic                     i_penable,
    input  logic                     i_pwrite,
    input  logic [`IAGC_ADDR_W-1:0]  i_paddr,
    input  logic [31:0]              i_pwdata,
    output logic [31:0]              o_prdata,
    output logic                     o_pready,
    output logic                     o_pslverr,
    output iagc_reg_pkg::iagc_cfg_t  o_cfg,
    input  iagc_reg_pkg::iagc_stat_t i_stat
);

    logic                    access;
    logic                    mapped;
    logic                    wr_en;
    logic [31:0]             rdata;
    iagc_reg_pkg::iagc_cfg_t cfg_q;

    // Every access completes in its access phase
    assign o_pready = 1'b1;
    assign access   = i_psel && i_penable;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address decode and read mux
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        mapped = 1'b1;
        rdata  = '0;
        case (i_paddr)
            iagc_reg_pkg::REG_CTRL:   rdata = 32'(cfg_q.enable);
            iagc_reg_pkg::REG_WINDOW: rdata = 32'(cfg_q.window);
            iagc_reg_pkg::REG_DECIM:  rdata = 32'(cfg_q.decim);
            iagc_reg_pkg::REG_STATUS: rdata = 32'(i_stat);
            default:                  mapped = 1'b0;
        endcase
    end

    assign o_prdata  = access ? rdata : '0;

    // STATUS is read only, so a write there is refused like a bad offset
    assign o_pslverr = access &&
                       (!mapped || (i_pwrite && i_paddr == iagc_reg_pkg::REG_STATUS));

    assign wr_en = access && i_pwrite && mapped && (i_paddr != iagc_reg_pkg::REG_STATUS);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Configuration registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            cfg_q.enable <= 1'b0;
            cfg_q.window <= {{(`IAGC_WINDOW_W-1){1'b0}}, 1'b1};
            cfg_q.decim  <= '0;
        end else if (wr_en) begin
            case (i_paddr)
                iagc_reg_pkg::REG_CTRL: begin
                    cfg_q.enable <= i_pwdata[iagc_reg_pkg::CTRL_ENABLE_BIT];
                end
                iagc_reg_pkg::REG_WINDOW: begin
                    cfg_q.window <= i_pwdata[`IAGC_WINDOW_W-1:0];
                end
                iagc_reg_pkg::REG_DECIM: begin
                    cfg_q.decim <= i_pwdata[`IAGC_DECIM_W-1:0];
                end
                default: begin
                end
            endcase
        end
    end

    assign o_cfg = cfg_q;

endmodule

/* verilog/iagc_sequencer.sv */
`timescale 1ns/1ps
`include "iagc_defines.svh"

module iagc_sequencer (
    input  logic                        i_clock,
    input  logic                        i_arst_n,
    input  iagc_reg_pkg::iagc_cfg_t     i_cfg,
    output iagc_data_pkg::iagc_status_e o_iagc_status,
    output logic                        o_sample
);

    iagc_data_pkg::iagc_status_e status_q;
    logic [`IAGC_DECIM_W-1:0]    decim_cnt;
    logic                        decim_done;
    logic                        sample_q;
    logic                        running;

    // INIT lasts exactly one cycle before the loop runs
    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            status_q <= iagc_data_pkg::RESET;
        end else if (!i_cfg.enable) begin
            status_q <= iagc_data_pkg::RESET;
        end else begin
            case (status_q)
                iagc_data_pkg::RESET: status_q <= iagc_data_pkg::INIT;
                iagc_data_pkg::INIT:  status_q <= iagc_data_pkg::RUN;
                default:              status_q <= iagc_data_pkg::RUN;
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sample strobe, one pulse per decim+1
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign running = (status_q == iagc_data_pkg::RUN) && i_cfg.enable;

    // Compare with >= so a smaller decim written mid run still wraps at once
    assign decim_done = decim_cnt >= i_cfg.decim;

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            decim_cnt <= '0;
            sample_q  <= 1'b0;
        end else if (!running) begin
            decim_cnt <= '0;
            sample_q  <= 1'b0;
        end else if (decim_done) begin
            decim_cnt <= '0;
            sample_q  <= 1'b1;
        end else begin
            decim_cnt <= decim_cnt + 1'b1;
            sample_q  <= 1'b0;
        end
    end

    assign o_iagc_status = status_q;
    assign o_sample      = sample_q;

endmodule

/* verilog/iagc_top.sv */
`timescale 1ns/1ps
`include "iagc_defines.svh"

module iagc_top (
    input  logic                           i_clock,
    input  logic                           i_arst_n,
    input  logic                           i_psel,
    input  logic                           i_penable,
    input  logic                           i_pwrite,
    input  logic [`IAGC_ADDR_W-1:0]        i_paddr,
    input  logic [31:0]                    i_pwdata,
    output logic [31:0]                    o_prdata,
    output logic                           o_pready,
    output logic                           o_pslverr,
    input  iagc_data_pkg::sample_pair_t    i_samples,
    output logic signed [`IAGC_DATA_W-1:0] o_error,
    output logic                           o_valid,
    output logic                           o_in_phase
);

    iagc_reg_pkg::iagc_cfg_t     cfg;
    iagc_reg_pkg::iagc_stat_t    stat;
    iagc_data_pkg::iagc_status_e iagc_status;
    logic                        sample;

    iagc_regs u_regs (
        .i_clock   (i_clock),
        .i_arst_n  (i_arst_n),
        .i_psel    (i_psel),
        .i_penable (i_penable),
        .i_pwrite  (i_pwrite),
        .i_paddr   (i_paddr),
        .i_pwdata  (i_pwdata),
        .o_prdata  (o_prdata),
        .o_pready  (o_pready),
        .o_pslverr (o_pslverr),
        .o_cfg     (cfg),
        .i_stat    (stat)
    );

    iagc_sequencer u_sequencer (
        .i_clock       (i_clock),
        .i_arst_n      (i_arst_n),
        .i_cfg         (cfg),
        .o_iagc_status (iagc_status),
        .o_sample      (sample)
    );

    phase_detector u_detector (
        .i_clock       (i_clock),
        .i_arst_n      (i_arst_n),
        .i_sample      (sample),
        .i_iagc_status (iagc_status),
        .i_samples     (i_samples),
        .i_cfg         (cfg),
        .o_stat        (stat),
        .o_in_phase    (o_in_phase)
    );

    // The corrector acts on the decision held before this strobe's window closes
    polarity_corrector u_corrector (
        .i_clock    (i_clock),
        .i_arst_n   (i_arst_n),
        .i_sample   (sample),
        .i_in_phase (o_in_phase),
        .i_error    (i_samples.error),
        .o_error    (o_error),
        .o_valid    (o_valid)
    );

endmodule

/* verilog/phase_detector.sv */
`timescale 1ns/1ps
`include "iagc_defines.svh"

module phase_detector (
    input  logic                        i_clock,
    input  logic                        i_arst_n,
    input  logic                        i_sample,
    input  iagc_data_pkg::iagc_status_e i_iagc_status,
    input  iagc_data_pkg::sample_pair_t i_samples,
    input  iagc_reg_pkg::iagc_cfg_t     i_cfg,
    output iagc_reg_pkg::iagc_stat_t    o_stat,
    output logic                        o_in_phase
);

    iagc_data_pkg::detect_state_e           state_q;
    iagc_data_pkg::detect_state_e           state_d;
    logic [`IAGC_WINDOW_W-1:0]              window_len;
    logic [`IAGC_WINDOW_W-1:0]              samples;
    logic [`IAGC_WINDOW_W-1:0]              agree_cnt;
    logic [`IAGC_WINDOW_W-1:0]              disagree_cnt;
    logic                                   pair_agree;
    logic                                   window_done;
    logic                                   in_phase_q;
    logic [iagc_reg_pkg::WIN_COUNT_W-1:0]   win_count;

    // A zero window would never close, run it as a single pair
    assign window_len = (i_cfg.window == '0) ? {{(`IAGC_WINDOW_W-1){1'b0}}, 1'b1} : i_cfg.window;

    // Equal sign bits mean both non-negative or both negative
    assign pair_agree  = i_samples.reference[`IAGC_DATA_W-1] == i_samples.error[`IAGC_DATA_W-1];
    assign window_done = i_sample && (samples >= window_len - 1'b1);

    always_comb begin
        state_d = state_q;
        case (state_q)
            iagc_data_pkg::D_INIT:   state_d = iagc_data_pkg::D_SAMPLE;
            iagc_data_pkg::D_SAMPLE: if (window_done) state_d = iagc_data_pkg::D_DETECT;
            iagc_data_pkg::D_DETECT: state_d = iagc_data_pkg::D_INIT;
            default:                 state_d = iagc_data_pkg::D_INIT;
        endcase
        if (i_iagc_status == iagc_data_pkg::RESET) begin
            state_d = iagc_data_pkg::D_INIT;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Window counters and decision
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q      <= iagc_data_pkg::D_INIT;
            samples      <= '0;
            agree_cnt    <= '0;
            disagree_cnt <= '0;
            in_phase_q   <= 1'b0;
            win_count    <= '0;
        end else begin
            state_q <= state_d;
            case (state_q)
                iagc_data_pkg::D_INIT: begin
                    samples      <= '0;
                    agree_cnt    <= '0;
                    disagree_cnt <= '0;
                end
                iagc_data_pkg::D_SAMPLE: begin
                    if (i_sample) begin
                        samples <= samples + 1'b1;
                        if (pair_agree) agree_cnt <= agree_cnt + 1'b1;
                        else            disagree_cnt <= disagree_cnt + 1'b1;
                    end
                end
                iagc_data_pkg::D_DETECT: begin
                    // A tie counts as in phase
                    in_phase_q <= agree_cnt >= disagree_cnt;
                    win_count  <= win_count + 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

    assign o_stat.in_phase  = in_phase_q;
    assign o_stat.win_count = win_count;
    assign o_in_phase       = in_phase_q;

endmodule

/* verilog/polarity_corrector.sv */
`timescale 1ns/1ps
`include "iagc_defines.svh"

module polarity_corrector (
    input  logic                           i_clock,
    input  logic                           i_arst_n,
    input  logic                           i_sample,
    input  logic                           i_in_phase,
    input  logic signed [`IAGC_DATA_W-1:0] i_error,
    output logic signed [`IAGC_DATA_W-1:0] o_error,
    output logic                           o_valid
);

    localparam logic signed [`IAGC_DATA_W-1:0] MOST_NEG = {1'b1, {(`IAGC_DATA_W-1){1'b0}}};
    localparam logic signed [`IAGC_DATA_W-1:0] MOST_POS = {1'b0, {(`IAGC_DATA_W-1){1'b1}}};

    logic signed [`IAGC_DATA_W-1:0] negated;
    logic signed [`IAGC_DATA_W-1:0] error_q;
    logic                           valid_q;

    // Two's complement negation overflows only at the most negative code
    assign negated = (i_error == MOST_NEG) ? MOST_POS : -i_error;

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            error_q <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= i_sample;
            if (i_sample) error_q <= i_in_phase ? i_error : negated;
        end
    end

    assign o_error = error_q;
    assign o_valid = valid_q;

endmodule
